// File: files.f
hw/textOverlayPkg.sv
hw/cellLocator.sv
hw/glyphRom.sv
hw/glyphRasterizer.sv
hw/textOverlay.sv
sim/clockGen.sv
sim/textOverlayTb.sv

// File: Bender.yml
package:
  name: text_overlay

sources:
  - files:
      - hw/textOverlayPkg.sv
      - hw/cellLocator.sv
      - hw/glyphRom.sv
      - hw/glyphRasterizer.sv
      - hw/textOverlay.sv
  - target: simulation
    files:
      - sim/clockGen.sv
      - sim/textOverlayTb.sv

// File: sim/textOverlayTb.sv
`timescale 1ns/1ps

module textOverlayTb import textOverlayPkg::*; ();

    localparam int ClockPeriod  = 10;
    localparam int MemWords     = GridCols * GridRows;
    localparam int GlyphEdge    = GlyphBlocks * BlockSize;
    localparam int FlushCycles  = 3;
    localparam int CellPixels   = CellSize * CellSize;
    localparam int MarginPixels = CellPixels - (GlyphEdge - 1) * GlyphEdge;

    // Stimulus length of each test, in clock cycles
    localparam int ResetCycles  = 16 + 3 + FlushCycles;
    localparam int AddrCycles   = 112 + 200 + FlushCycles;
    localparam int GlyphCycles  = (LastGlyph + 1) * CellPixels + FlushCycles;
    localparam int MarginCycles = GridCols * MarginPixels + FlushCycles;
    localparam int BlankCycles  = 4 * CellPixels + 424 + 584 + 2 * FlushCycles;
    localparam int PipeCycles   = 2000 + FlushCycles;
    localparam int TotalCycles  = ResetCycles + AddrCycles + GlyphCycles
                                + MarginCycles + BlankCycles + PipeCycles;

    logic                 clk;
    logic                 reset;
    countT                hcount;
    countT                vcount;
    cellAddrT             address;
    logic [DataWidth-1:0] data;
    pixelT                pixel;

    logic [DataWidth-1:0] textMem [MemWords];
    string                glyphArt [LastGlyph+1];
    logic [31:0]          lfsrState = 32'h005b_1813;

    // Reference pipeline, one stage per DUT register
    cellAddrT expAddr;
    pixelT    expPixel;
    pixelT    nextPixel;
    logic     addrCheck = 1'b0;
    logic     pixCheck = 1'b0;

    int errorCount = 0;
    int testsRun = 0;
    int testsFailed = 0;

    clockGen u_clock (
        .clk   (clk),
        .reset (reset)
    );

    textOverlay dut (
        .clk     (clk),
        .reset   (reset),
        .hcount  (hcount),
        .vcount  (vcount),
        .address (address),
        .data    (data),
        .pixel   (pixel)
    );

    // Text memory answers the address in the same cycle
    assign data = (address < MemWords) ? textMem[address] : '0;

    ////////////////////////////////////////////////////////////
    // Reference glyphs, rows top to bottom, # is a lit block
    ////////////////////////////////////////////////////////////

    initial
    begin
        glyphArt[0]  = "....... ....... ....... ....... ....... ....... .......";
        glyphArt[1]  = ".#####. #.....# #.....# #.....# ####### #.....# #.....#";
        glyphArt[2]  = "######. #.....# #.....# ####### #.....# #.....# ######.";
        glyphArt[3]  = "####### #...... #...... #...... #...... #...... #######";
        glyphArt[4]  = "######. #.....# #.....# #.....# #.....# #.....# ######.";
        glyphArt[5]  = "####### #...... #...... #####.. #...... #...... #######";
        glyphArt[6]  = "####### #...... #...... ####### #...... #...... #......";
        glyphArt[7]  = "####### #...... #...... ####### #.....# #.....# #######";
        glyphArt[8]  = "#.....# #.....# #.....# ####### #.....# #.....# #.....#";
        glyphArt[9]  = "####### ...#... ...#... ...#... ...#... ...#... #######";
        glyphArt[10] = "####### ...#... ...#... #..#... #..#... #..#... ####...";
        glyphArt[11] = "#.....# #....#. #...#.. ####... #...#.. #....#. #.....#";
        glyphArt[12] = "#...... #...... #...... #...... #...... #...... #######";
    end

    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            value     = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic inArea(input int h, input int v);
        return (h < ActiveWidth) && (v < ActiveHeight);
    endfunction

    function automatic cellAddrT cellAddress(input int h, input int v);
        return cellAddrT'((v / CellSize) * GridCols + h / CellSize);
    endfunction

    function automatic pixelT expectedPixel(input int h, input int v);
        logic [DataWidth-1:0] word;
        string                art;
        int                   dx;
        int                   dy;
        if (!inArea(h, v))
            return '0;
        word = textMem[cellAddress(h, v)];
        dx   = h % CellSize;
        dy   = v % CellSize;
        if (dx == 0 || dx >= GlyphEdge || dy >= GlyphEdge || word > LastGlyph)
            return '0;
        art = glyphArt[int'(word)];
        // Eight characters per row, the last one a separator
        if (art[(dy / BlockSize) * 8 + dx / BlockSize] == "#")
            return PixelOn;
        return '0;
    endfunction

    ////////////////////////////////////////////////////////////
    // Checker
    ////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (addrCheck)
        begin
            assert (address === expAddr)
            else
            begin
                errorCount++;
                $display("CHECK FAILED at time %0t: address %0d, expected %0d",
                         $time, address, expAddr);
            end
        end
        if (pixCheck)
        begin
            assert (pixel === expPixel)
            else
            begin
                errorCount++;
                $display("CHECK FAILED at time %0t: pixel %0h, expected %0h",
                         $time, pixel, expPixel);
            end
        end
        if (reset)
        begin
            expAddr   = '0;
            expPixel  = '0;
            nextPixel = '0;
            addrCheck = 1'b1;
            pixCheck  = 1'b1;
        end
        else
        begin
            expPixel  = nextPixel;
            nextPixel = expectedPixel(hcount, vcount);
            expAddr   = cellAddress(hcount, vcount);
            // Address is don't care off screen
            addrCheck = inArea(hcount, vcount);
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic drivePos(input int h, input int v);
        @(negedge clk);
        hcount = countT'(h);
        vcount = countT'(v);
    endtask

    // Off-screen positions until the last real one has left the pipe
    task automatic flushPipe();
        repeat (FlushCycles) drivePos(1023, 1023);
    endtask

    task automatic driveCellCorners(input int col, input int row);
        drivePos(col * CellSize, row * CellSize);
        drivePos(col * CellSize + CellSize - 1, row * CellSize + CellSize - 1);
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        int found;
        found = errorCount - errorsBefore;
        testsRun++;
        if (found == 0)
            $display("test %s: passed", name);
        else
        begin
            testsFailed++;
            $display("test %s: failed with %0d errors", name, found);
        end
    endtask

    initial
    begin
        int errorsBefore;
        // Lit block of cell 17 held while reset is high
        hcount = countT'(CellSize + 10);
        vcount = countT'(CellSize + 2);
        for (int i = 0; i < MemWords; i++)
            textMem[i] = 1;

        errorsBefore = errorCount;
        @(negedge reset);
        hcount = '0;
        vcount = '0;
        repeat (3) drivePos(0, 0);
        flushPipe();
        reportTest("reset", errorsBefore);

        errorsBefore = errorCount;
        for (int c = 0; c < GridCols; c++)
        begin
            driveCellCorners(c, 0);
            driveCellCorners(c, GridRows - 1);
        end
        for (int r = 0; r < GridRows; r++)
        begin
            driveCellCorners(0, r);
            driveCellCorners(GridCols - 1, r);
        end
        repeat (200) drivePos(randomBits(10) % ActiveWidth, randomBits(9) % ActiveHeight);
        flushPipe();
        reportTest("address", errorsBefore);

        errorsBefore = errorCount;
        for (int i = 0; i < MemWords; i++)
            textMem[i] = DataWidth'(i % (LastGlyph + 1));
        for (int v = 0; v < CellSize; v++)
            for (int h = 0; h < (LastGlyph + 1) * CellSize; h++)
                drivePos(h, v);
        flushPipe();
        reportTest("glyph rendering", errorsBefore);

        errorsBefore = errorCount;
        for (int i = 0; i < MemWords; i++)
            textMem[i] = DataWidth'(i % GridCols);
        for (int v = 0; v < CellSize; v++)
            for (int h = 0; h < ActiveWidth; h++)
                if ((h % CellSize == 0) || (h % CellSize >= GlyphEdge) || (v >= GlyphEdge))
                    drivePos(h, v);
        flushPipe();
        reportTest("margins", errorsBefore);

        errorsBefore = errorCount;
        // Codes past the table, most with a lit glyph in the low bits
        for (int i = 0; i < MemWords; i++)
            textMem[i] = DataWidth'(LastGlyph + 1 + i * 20);
        for (int v = 0; v < CellSize; v++)
            for (int h = 0; h < 4 * CellSize; h++)
                drivePos(h, v);
        flushPipe();
        // Lit glyph everywhere, so only the area edge can blank it
        for (int i = 0; i < MemWords; i++)
            textMem[i] = 1;
        for (int h = 600; h < 1024; h++)
            drivePos(h, 10);
        for (int v = 440; v < 1024; v++)
            drivePos(20, v);
        flushPipe();
        reportTest("blanking", errorsBefore);

        errorsBefore = errorCount;
        for (int i = 0; i < MemWords; i++)
            textMem[i] = randomBits(4);
        repeat (2000) drivePos(randomBits(10) % 704, randomBits(9));
        flushPipe();
        reportTest("pipelining", errorsBefore);

        $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
                 testsRun, testsRun - testsFailed, testsFailed, errorCount);
        if (testsFailed == 0 && errorCount == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        #(2 * TotalCycles * ClockPeriod);
        $display("Watchdog expired before the stimulus finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: sim/clockGen.sv
`timescale 1ns/1ps

module clockGen
(
    output logic clk,
    output logic reset
);

    localparam int HalfPeriod  = 5;
    localparam int ResetCycles = 16;

    initial
    begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    // Released on a falling edge, away from the sampling edge
    initial
    begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: hw/textOverlay.sv
`timescale 1ns/1ps

module textOverlay import textOverlayPkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  countT                hcount,
    input  countT                vcount,
    output cellAddrT             address,
    input  logic [DataWidth-1:0] data,
    output pixelT                pixel
);

    offsetT   dx;
    offsetT   dy;
    logic     active;
    blockT    blockRow;
    glyphRowT rowBits;

    // Stage 1, cell address out to the text memory
    cellLocator u_locator (
        .clk     (clk),
        .reset   (reset),
        .hcount  (hcount),
        .vcount  (vcount),
        .address (address),
        .dx      (dx),
        .dy      (dy),
        .active  (active)
    );

    glyphRom u_rom (
        .glyphCode (data),
        .blockRow  (blockRow),
        .rowBits   (rowBits)
    );

    // Stage 2, symbol code back from memory
    glyphRasterizer u_raster (
        .clk       (clk),
        .reset     (reset),
        .dx        (dx),
        .dy        (dy),
        .active    (active),
        .glyphCode (data),
        .rowBits   (rowBits),
        .blockRow  (blockRow),
        .pixel     (pixel)
    );

endmodule

// File: hw/glyphRasterizer.sv
`timescale 1ns/1ps

module glyphRasterizer import textOverlayPkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  offsetT               dx,
    input  offsetT               dy,
    input  logic                 active,
    input  logic [DataWidth-1:0] glyphCode,
    input  glyphRowT             rowBits,
    output blockT                blockRow,
    output pixelT                pixel
);

    blockT blockCol;
    blockT bitSel;
    logic  inGlyph;
    logic  lit;

    ////////////////////////////////////////////////////////////
    // Block lookup
    ////////////////////////////////////////////////////////////

    assign blockRow = blockT'(dy / BlockSize);
    assign blockCol = blockT'(dx / BlockSize);

    // Leftmost block sits in the top bit of the row
    assign bitSel = blockT'(GlyphBlocks - 1) - blockCol;

    // Column 0 is the left margin of every cell
    assign inGlyph = (dx != '0)
                  && (dx < offsetT'(GlyphSpan))
                  && (dy < offsetT'(GlyphSpan));

    always_comb
    begin
        lit = 1'b0;
        if (active && inGlyph)
            lit = rowBits[bitSel];
    end

    ////////////////////////////////////////////////////////////
    // Pixel register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
            pixel <= '0;
        else
            pixel <= lit ? PixelOn : '0;
    end

endmodule

// File: hw/glyphRom.sv
`timescale 1ns/1ps

module glyphRom import textOverlayPkg::*;
(
    input  logic [DataWidth-1:0] glyphCode,
    input  blockT                blockRow,
    output glyphRowT             rowBits
);

    logic [CodeWidth-1:0] glyphIdx;

    ////////////////////////////////////////////////////////////
    // Bitmaps, top row first
    ////////////////////////////////////////////////////////////

    localparam glyphRowT GlyphTable [LastGlyph+1][GlyphBlocks] = '{
        // Space
        '{default: '0},
        // A
        '{7'b0111110,
          7'b1000001,
          7'b1000001,
          7'b1000001,
          7'b1111111,
          7'b1000001,
          7'b1000001},
        // B
        '{7'b1111110,
          7'b1000001,
          7'b1000001,
          7'b1111111,
          7'b1000001,
          7'b1000001,
          7'b1111110},
        // C
        '{7'b1111111,
          7'b1000000,
          7'b1000000,
          7'b1000000,
          7'b1000000,
          7'b1000000,
          7'b1111111},
        // D
        '{7'b1111110,
          7'b1000001,
          7'b1000001,
          7'b1000001,
          7'b1000001,
          7'b1000001,
          7'b1111110},
        // E, middle bar one block short
        '{7'b1111111,
          7'b1000000,
          7'b1000000,
          7'b1111100,
          7'b1000000,
          7'b1000000,
          7'b1111111},
        // F
        '{7'b1111111,
          7'b1000000,
          7'b1000000,
          7'b1111111,
          7'b1000000,
          7'b1000000,
          7'b1000000},
        // G
        '{7'b1111111,
          7'b1000000,
          7'b1000000,
          7'b1111111,
          7'b1000001,
          7'b1000001,
          7'b1111111},
        // H
        '{7'b1000001,
          7'b1000001,
          7'b1000001,
          7'b1111111,
          7'b1000001,
          7'b1000001,
          7'b1000001},
        // I
        '{7'b1111111,
          7'b0001000,
          7'b0001000,
          7'b0001000,
          7'b0001000,
          7'b0001000,
          7'b1111111},
        // J
        '{7'b1111111,
          7'b0001000,
          7'b0001000,
          7'b1001000,
          7'b1001000,
          7'b1001000,
          7'b1111000},
        // K
        '{7'b1000001,
          7'b1000010,
          7'b1000100,
          7'b1111000,
          7'b1000100,
          7'b1000010,
          7'b1000001},
        // L
        '{7'b1000000,
          7'b1000000,
          7'b1000000,
          7'b1000000,
          7'b1000000,
          7'b1000000,
          7'b1111111}
    };

    assign glyphIdx = glyphCode[CodeWidth-1:0];

    // Unknown codes and the row below the glyph read as empty
    always_comb
    begin
        rowBits = '0;
        if ((glyphCode <= DataWidth'(LastGlyph)) && (blockRow < BlockWidth'(GlyphBlocks)))
            rowBits = GlyphTable[glyphIdx][blockRow];
    end

endmodule

// File: hw/cellLocator.sv
`timescale 1ns/1ps

module cellLocator import textOverlayPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  countT    hcount,
    input  countT    vcount,
    output cellAddrT address,
    output offsetT   dx,
    output offsetT   dy,
    output logic     active
);

    logic [ColWidth-1:0] colIdx;
    logic [RowWidth-1:0] rowIdx;
    countT               colBase;
    countT               rowBase;
    logic                inArea;

    ////////////////////////////////////////////////////////////
    // Cell search
    ////////////////////////////////////////////////////////////

    // Last multiple of the cell size not above the count wins
    always_comb
    begin
        colIdx  = '0;
        colBase = '0;
        for (int c = 1; c < GridCols; c++)
        begin
            if (hcount >= countT'(c * CellSize))
            begin
                colIdx  = ColWidth'(c);
                colBase = countT'(c * CellSize);
            end
        end
    end

    always_comb
    begin
        rowIdx  = '0;
        rowBase = '0;
        for (int r = 1; r < GridRows; r++)
        begin
            if (vcount >= countT'(r * CellSize))
            begin
                rowIdx  = RowWidth'(r);
                rowBase = countT'(r * CellSize);
            end
        end
    end

    assign inArea = (hcount < countT'(ActiveWidth)) && (vcount < countT'(ActiveHeight));

    ////////////////////////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            address <= '0;
            dx      <= '0;
            dy      <= '0;
            active  <= 1'b0;
        end
        else
        begin
            address <= cellAddrT'(rowIdx * GridCols + colIdx);
            // Only meaningful inside the active area
            dx      <= offsetT'(hcount - colBase);
            dy      <= offsetT'(vcount - rowBase);
            active  <= inArea;
        end
    end

endmodule

// File: hw/textOverlayPkg.sv
package textOverlayPkg;

    ////////////////////////////////////////////////////////////
    // Raster and cell geometry
    ////////////////////////////////////////////////////////////

    localparam int CountWidth   = 10;
    localparam int ActiveWidth  = 640;
    localparam int ActiveHeight = 480;

    localparam int CellSize    = 40;
    localparam int GridCols    = 16;
    localparam int GridRows    = 12;
    localparam int ColWidth    = $clog2(GridCols);
    localparam int RowWidth    = $clog2(GridRows);
    localparam int OffsetWidth = $clog2(CellSize);

    ////////////////////////////////////////////////////////////
    // Glyph layout
    ////////////////////////////////////////////////////////////

    localparam int BlockSize   = 5;
    localparam int GlyphBlocks = 7;

    // Offsets at or past this edge are outside the glyph
    localparam int GlyphSpan = GlyphBlocks * BlockSize;

    // One extra code so dy/5 up to 7 still fits
    localparam int BlockWidth = $clog2(GlyphBlocks + 1);

    ////////////////////////////////////////////////////////////
    // Text memory and pixel
    ////////////////////////////////////////////////////////////

    localparam int AddrWidth  = 8;
    localparam int DataWidth  = 32;
    localparam int LastGlyph  = 12;
    localparam int CodeWidth  = $clog2(LastGlyph + 1);
    localparam int PixelWidth = 8;

    typedef logic [CountWidth-1:0]  countT;
    typedef logic [OffsetWidth-1:0] offsetT;
    typedef logic [BlockWidth-1:0]  blockT;
    typedef logic [AddrWidth-1:0]   cellAddrT;
    typedef logic [PixelWidth-1:0]  pixelT;

    // Bit 6 is the leftmost block
    typedef logic [GlyphBlocks-1:0] glyphRowT;

    localparam pixelT PixelOn = '1;

endpackage
